// File: dv/exec_golden.txt
// first word is the vector count, then one vector per line
// instr_word result flags ; flags bit3 = issue with no idle gap
// flags bits 2:0 = overflow negative zero
0021
7000 00 1
F47F 7F 0
F801 01 0
FC80 80 2
0D80 80 6
1F80 7F C
5F00 80 E
0FC0 00 D
FCF0 F0 2
0F40 6F 8
1A40 82 2
1580 FD E
5500 FE A
8A7F 01 0
9A02 FF A
F43C 3C 0
F8A5 A5 2
2D80 24 8
3D80 BD 2
4D80 99 2
4FC0 00 9
6E00 A5 2
74C0 A5 A
AA0F 05 0
BAF0 F5 A
CAF5 00 9
ED55 A5 2
1540 00 1
1FC0 00 1
5500 01 8
0940 02 8
8F80 80 2
DF00 81 A

// File: vlog.f
verilog/alu_pkg.sv
verilog/isa_pkg.sv
verilog/arith_unit.sv
verilog/logic_unit.sv
verilog/alu.sv
verilog/reg_file.sv
verilog/exec_stage.sv
dv/tb_clkgen.sv
dv/exec_stage_chk.sv
dv/tb_exec_stage.sv

// File: Makefile
TOP := tb_exec_stage
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f vlog.f --top-module exec_stage

sim:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	  -f vlog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; \
	  exit 1; \
	elif ! grep -q "Simulation PASSED" $(LOG); then \
	  echo "simulation ended without a verdict, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// File: dv/tb_exec_stage.sv
`timescale 1ns/1ps

module tb_exec_stage
  import alu_pkg::*;
  import isa_pkg::*;
();

  localparam int          BW            = 8;
  localparam int          PERIOD_NS     = 40;
  localparam int          RESET_CYCLES  = 5;
  // drive point and sample point after the rising edge
  localparam int          DRIVE_DELAY   = 2;
  localparam int          SAMPLE_DELAY  = 1;
  localparam int          VALID_TIMEOUT = 10;
  localparam int          MAX_VECS      = 40;
  // count word, then three words per vector
  localparam int          GOLDEN_WORDS  = 1 + 3 * MAX_VECS;
  localparam logic [31:0] SEED          = 32'h78b9fcd9;

  logic          clk_i;
  logic          rst_i;
  logic          valid_i;
  instr_u        instr_i;
  logic          valid_o;
  logic [BW-1:0] result_o;
  alu_flags_t    flags_o;

  logic [15:0]   golden_mem [GOLDEN_WORDS];
  logic [31:0]   rand_state;

  tb_clkgen #(
    .PERIOD_NS(PERIOD_NS)
  ) tb_clkgen_inst (
    .clk_o(clk_i)
  );

  exec_stage #(
    .BW(BW)
  ) exec_stage_inst (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .valid_i (valid_i),
    .instr_i (instr_i),
    .valid_o (valid_o),
    .result_o(result_o),
    .flags_o (flags_o)
  );

  // --------------------------------------------------------------------------
  // helpers
  // --------------------------------------------------------------------------

  // numerical recipes lcg
  function automatic logic [31:0] next_rand(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [15:0] expected,
                             input logic [15:0] actual);
    if (expected !== actual) begin
      stop_with_failure($sformatf("Fail %s expected %h actual %h", name, expected, actual));
    end
  endtask

  // returns at edge + SAMPLE_DELAY with valid_o high
  task automatic wait_for_valid(input int idx);
    int waited;
    waited = 0;
    do begin
      @(posedge clk_i);
      #SAMPLE_DELAY;
      waited++;
      if (!valid_o && waited >= VALID_TIMEOUT) begin
        stop_with_failure($sformatf("valid_o never rose within %0d cycles for vector %0d",
                                    VALID_TIMEOUT, idx));
      end
    end while (!valid_o);
  endtask

  // --------------------------------------------------------------------------
  // stimulus
  // --------------------------------------------------------------------------

  initial begin
    int          n_vecs;
    int          gap;
    int          waited;
    logic [15:0] word;
    logic [15:0] exp_res;
    logic [15:0] exp_flags;
    logic        chained;
    rst_i      = 1'b1;
    valid_i    = 1'b0;
    instr_i    = '0;
    rand_state = SEED;
    $readmemh("dv/exec_golden.txt", golden_mem);
    n_vecs = int'(golden_mem[0]);
    if (n_vecs == 0 || n_vecs > MAX_VECS) begin
      stop_with_failure("golden file holds no usable vector count");
    end

    repeat (RESET_CYCLES) @(posedge clk_i);
    #DRIVE_DELAY;
    rst_i = 1'b0;

    // outputs cleared by reset
    check_value("reset valid_o", 16'h0, 16'(valid_o));
    check_value("reset result_o", 16'h0, 16'(result_o));
    check_value("reset flags_o", 16'h0, 16'(flags_o));

    for (int i = 0; i < n_vecs; i++) begin
      word      = golden_mem[1 + 3 * i];
      exp_res   = golden_mem[2 + 3 * i];
      exp_flags = golden_mem[3 + 3 * i];
      // bit 3 forces back to back issue
      chained   = exp_flags[3];
      if (!chained) begin
        valid_i    = 1'b0;
        rand_state = next_rand(rand_state);
        gap        = int'(rand_state[17:16]);
        repeat (gap) begin
          @(posedge clk_i);
          #DRIVE_DELAY;
        end
      end
      instr_i = word;
      valid_i = 1'b1;
      wait_for_valid(i);
      check_value($sformatf("vec%0d result", i), exp_res, 16'(result_o));
      check_value($sformatf("vec%0d flags", i), {13'd0, exp_flags[2:0]}, 16'(flags_o));
      // back to the drive point
      #(DRIVE_DELAY - SAMPLE_DELAY);
    end

    // drain, pulse must drop once input goes idle
    valid_i = 1'b0;
    waited  = 0;
    do begin
      @(posedge clk_i);
      #SAMPLE_DELAY;
      waited++;
      if (valid_o && waited >= VALID_TIMEOUT) begin
        stop_with_failure("valid_o stayed high after the last instruction");
      end
    end while (valid_o);

    if (exec_stage_inst.chk_inst.err_count != 0) begin
      stop_with_failure("bound checker reported assertion failures");
    end else begin
      $display("Simulation PASSED");
      $finish;
    end
  end

endmodule

// File: dv/exec_stage_chk.sv
`timescale 1ns/1ps

module exec_stage_chk
  import alu_pkg::*;
#(
  parameter int BW = 8
) (
  input logic          clk_i,
  input logic          rst_i,
  input logic          valid_i,
  input logic          valid_o,
  input logic [BW-1:0] result_o,
  input alu_flags_t    flags_o
);

  // running count of failed assertions
  int unsigned err_count = 0;

  // --------------------------------------------------------------------------
  // valid pulse
  // --------------------------------------------------------------------------

  // every accepted instruction shows up one edge later
  valid_follows: assert property (@(posedge clk_i) disable iff (rst_i)
    valid_i |=> valid_o)
    else begin
      $error("valid_o did not follow valid_i");
      err_count++;
    end

  // no valid_i, no pulse
  valid_single: assert property (@(posedge clk_i) disable iff (rst_i)
    !valid_i |=> !valid_o)
    else begin
      $error("valid_o high without a preceding valid_i");
      err_count++;
    end

  // --------------------------------------------------------------------------
  // flags against the registered result
  // --------------------------------------------------------------------------

  zero_matches: assert property (@(posedge clk_i) disable iff (rst_i)
    valid_o |-> (flags_o.zero == (result_o == '0)))
    else begin
      $error("zero flag disagrees with result_o");
      err_count++;
    end

  // sign bit copy
  neg_matches: assert property (@(posedge clk_i) disable iff (rst_i)
    valid_o |-> (flags_o.negative == result_o[BW-1]))
    else begin
      $error("negative flag disagrees with result_o msb");
      err_count++;
    end

  // reset edge always clears the pulse
  reset_quiet: assert property (@(posedge clk_i) rst_i |=> !valid_o)
    else begin
      $error("valid_o high while in reset");
      err_count++;
    end

endmodule

// attach to every exec_stage instance
bind exec_stage exec_stage_chk #(
  .BW(BW)
) chk_inst (
  .clk_i   (clk_i),
  .rst_i   (rst_i),
  .valid_i (valid_i),
  .valid_o (valid_o),
  .result_o(result_o),
  .flags_o (flags_o)
);

// File: dv/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
  parameter int PERIOD_NS = 40
) (
  output logic clk_o
);

  // free-running, low at time zero
  initial begin
    clk_o = 1'b0;
  end

  // half period per toggle
  always begin
    #(PERIOD_NS / 2);
    clk_o = ~clk_o;
  end

endmodule

// File: verilog/exec_stage.sv
`timescale 1ns/1ps

module exec_stage
  import alu_pkg::*;
  import isa_pkg::*;
#(
  parameter int BW = 8
) (
  input  logic          clk_i,
  input  logic          rst_i,
  input  logic          valid_i,
  input  instr_u        instr_i,
  output logic          valid_o,
  output logic [BW-1:0] result_o,
  output alu_flags_t    flags_o
);

  // decoded fields
  logic                is_imm;
  alu_op_e             dec_op;
  reg_idx_t            dec_rd;
  reg_idx_t            dec_rs_a;
  reg_idx_t            dec_rs_b;
  logic [IMM_W-1:0]    dec_imm;
  // imm sign-extended past BW, low BW bits taken
  logic [BW+IMM_W-1:0] imm_ext;
  // operands
  logic [BW-1:0]       rf_a;
  logic [BW-1:0]       rf_b;
  logic [BW-1:0]       op_b;
  // alu outputs
  logic [BW-1:0]       alu_result;
  alu_flags_t          alu_flags;

  // --------------------------------------------------------------------------
  // decode
  // --------------------------------------------------------------------------

  // fmt picks the view of the union
  // op, rd and rs_a sit at the same bits in both views
  always_comb begin
    is_imm   = 1'b0;
    dec_op   = instr_i.rr.op;
    dec_rd   = instr_i.rr.rd;
    dec_rs_a = instr_i.rr.rs_a;
    dec_rs_b = instr_i.rr.rs_b;
    dec_imm  = '0;
    case (instr_i.rr.fmt)
      FMT_REG: begin
        dec_rs_b = instr_i.rr.rs_b;
      end
      FMT_IMM: begin
        is_imm   = 1'b1;
        // port b idles on r0
        dec_rs_b = '0;
        dec_imm  = instr_i.ri.imm;
      end
    endcase
  end

  assign imm_ext = {{BW{dec_imm[IMM_W-1]}}, dec_imm};
  // imm replaces register b in i-format
  assign op_b    = is_imm ? imm_ext[BW-1:0] : rf_b;

  // register file, written back on the issue edge
  reg_file #(
    .BW(BW)
  ) reg_file_inst (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .rd_a_idx_i(dec_rs_a),
    .rd_b_idx_i(dec_rs_b),
    .rd_a_o    (rf_a),
    .rd_b_o    (rf_b),
    .we_i      (valid_i),
    .wr_idx_i  (dec_rd),
    .wr_data_i (alu_result)
  );

  alu #(
    .BW(BW)
  ) alu_inst (
    .a_i     (rf_a),
    .b_i     (op_b),
    .op_i    (dec_op),
    .result_o(alu_result),
    .flags_o (alu_flags)
  );

  // --------------------------------------------------------------------------
  // output registers
  // --------------------------------------------------------------------------

  // one-cycle valid pulse, result held until next instruction
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_o  <= 1'b0;
      result_o <= '0;
      flags_o  <= '0;
    end else begin
      valid_o <= valid_i;
      if (valid_i) begin
        result_o <= alu_result;
        flags_o  <= alu_flags;
      end
    end
  end

endmodule

// File: verilog/reg_file.sv
`timescale 1ns/1ps

module reg_file
  import isa_pkg::*;
#(
  parameter int BW = 8
) (
  input  logic          clk_i,
  input  logic          rst_i,
  // read port a
  input  reg_idx_t      rd_a_idx_i,
  // read port b
  input  reg_idx_t      rd_b_idx_i,
  output logic [BW-1:0] rd_a_o,
  output logic [BW-1:0] rd_b_o,
  // write port
  input  logic          we_i,
  input  reg_idx_t      wr_idx_i,
  input  logic [BW-1:0] wr_data_i
);

  // --------------------------------------------------------------------------
  // storage
  // --------------------------------------------------------------------------

  logic [BW-1:0] regs_q [REG_COUNT];

  // all registers read as zero after reset
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < REG_COUNT; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i) begin
      regs_q[wr_idx_i] <= wr_data_i;
    end
  end

  // --------------------------------------------------------------------------
  // reads
  // --------------------------------------------------------------------------

  // combinational, so the next instruction sees
  // the value written on the previous edge
  assign rd_a_o = regs_q[rd_a_idx_i];
  assign rd_b_o = regs_q[rd_b_idx_i];

endmodule

// File: verilog/alu.sv
`timescale 1ns/1ps

module alu
  import alu_pkg::*;
#(
  parameter int BW = 8
) (
  input  logic [BW-1:0] a_i,
  input  logic [BW-1:0] b_i,
  input  alu_op_e       op_i,
  output logic [BW-1:0] result_o,
  output alu_flags_t    flags_o
);

  // --------------------------------------------------------------------------
  // sub-unit results
  // --------------------------------------------------------------------------

  logic [BW-1:0] arith_res;
  logic          arith_ovf;
  logic [BW-1:0] logic_res;
  // high for add/sub/inc
  logic          sel_arith;

  // adder side
  arith_unit #(
    .BW(BW)
  ) arith_unit_inst (
    .a_i       (a_i),
    .b_i       (b_i),
    .op_i      (op_i),
    .sum_o     (arith_res),
    .overflow_o(arith_ovf)
  );

  // bitwise side
  logic_unit #(
    .BW(BW)
  ) logic_unit_inst (
    .a_i  (a_i),
    .b_i  (b_i),
    .op_i (op_i),
    .res_o(logic_res)
  );

  // --------------------------------------------------------------------------
  // result select and flags
  // --------------------------------------------------------------------------

  assign sel_arith = is_arith_op(op_i);

  // pick by opcode class
  assign result_o = sel_arith ? arith_res : logic_res;

  always_comb begin
    flags_o = '0;
    // logic ops never overflow
    flags_o.overflow = sel_arith & arith_ovf;
    // sign bit of the chosen result
    flags_o.negative = result_o[BW-1];
    flags_o.zero     = (result_o == '0);
  end

endmodule

// File: verilog/logic_unit.sv
`timescale 1ns/1ps

module logic_unit
  import alu_pkg::*;
#(
  parameter int BW = 8
) (
  input  logic [BW-1:0] a_i,
  input  logic [BW-1:0] b_i,
  input  alu_op_e       op_i,
  output logic [BW-1:0] res_o
);

  // bitwise ops and moves, arithmetic opcodes give zero
  always_comb begin
    res_o = '0;
    case (op_i)
      OP_AND: begin
        res_o = a_i & b_i;
      end
      OP_OR: begin
        res_o = a_i | b_i;
      end
      OP_XOR: begin
        res_o = a_i ^ b_i;
      end
      // register copy
      OP_MOVA: begin
        res_o = a_i;
      end
      // immediate load path in i-format
      OP_MOVB: begin
        res_o = b_i;
      end
      // add, sub, inc handled by arith_unit
      default: begin
        res_o = '0;
      end
    endcase
  end

endmodule

// File: verilog/arith_unit.sv
`timescale 1ns/1ps

module arith_unit
  import alu_pkg::*;
#(
  parameter int BW = 8
) (
  input  logic [BW-1:0] a_i,
  input  logic [BW-1:0] b_i,
  input  alu_op_e       op_i,
  output logic [BW-1:0] sum_o,
  output logic          overflow_o
);

  // adder b input after sub/inc conditioning
  logic [BW-1:0] b_eff;
  logic          c_in;
  // per-bit generate and propagate
  logic [BW-1:0] gen;
  logic [BW-1:0] prop;
  // carry into each bit position
  logic [BW-1:0] carry;

  // sub is a + ~b + 1, inc is a + 1
  always_comb begin
    b_eff = b_i;
    c_in  = 1'b0;
    case (op_i)
      OP_SUB: begin
        b_eff = ~b_i;
        c_in  = 1'b1;
      end
      OP_INC: begin
        b_eff = BW'(1);
      end
      default: begin
        b_eff = b_i;
      end
    endcase
  end

  assign gen  = a_i & b_eff;
  assign prop = a_i ^ b_eff;

  // flat lookahead, each carry expanded over all lower stages and c_in
  always_comb begin
    logic run;
    logic c_acc;
    carry[0] = c_in;
    for (int i = 1; i < BW; i++) begin
      c_acc = gen[i-1];
      run   = prop[i-1];
      for (int j = i - 2; j >= 0; j--) begin
        c_acc = c_acc | (run & gen[j]);
        run   = run & prop[j];
      end
      carry[i] = c_acc | (run & c_in);
    end
  end

  assign sum_o = prop ^ carry;

  // same-sign operands, different-sign result
  always_comb begin
    overflow_o = 1'b0;
    if (is_arith_op(op_i)) begin
      overflow_o = (a_i[BW-1] == b_eff[BW-1]) && (sum_o[BW-1] != a_i[BW-1]);
    end
  end

endmodule

// File: verilog/isa_pkg.sv
package isa_pkg;
  import alu_pkg::*;

  // -------------------------------------------------------------------------
  // register file and immediate sizes
  // -------------------------------------------------------------------------

  localparam int REG_COUNT = 4;
  localparam int IMM_W     = 8;

  // format bit, msb of every instruction word
  localparam logic FMT_REG = 1'b0;
  localparam logic FMT_IMM = 1'b1;

  typedef logic [$clog2(REG_COUNT)-1:0] reg_idx_t;

  // register-register, 16 bits
  typedef struct packed {
    logic       fmt;
    alu_op_e    op;
    reg_idx_t   rd;
    reg_idx_t   rs_a;
    reg_idx_t   rs_b;
    // unused low bits, keep zero
    logic [5:0] pad;
  } instr_r_t;

  // register-immediate, imm takes the place of rs_b and pad
  typedef struct packed {
    logic             fmt;
    alu_op_e          op;
    reg_idx_t         rd;
    reg_idx_t         rs_a;
    logic [IMM_W-1:0] imm;
  } instr_i_t;

  // one word, two views; fmt lines up in both
  typedef union packed {
    instr_r_t rr;
    instr_i_t ri;
  } instr_u;

endpackage

// File: verilog/alu_pkg.sv
package alu_pkg;

  // -------------------------------------------------------------------------
  // opcode encoding
  // -------------------------------------------------------------------------

  // width of the opcode field in both instruction formats
  localparam int ALU_OP_W = 3;

  // fixed by the isa, do not reorder
  typedef enum logic [ALU_OP_W-1:0] {
    // a + b
    OP_ADD  = 3'b000,
    // a + ~b + 1
    OP_SUB  = 3'b001,
    OP_AND  = 3'b010,
    OP_OR   = 3'b011,
    OP_XOR  = 3'b100,
    // a + 1, b ignored
    OP_INC  = 3'b101,
    // pass operand a
    OP_MOVA = 3'b110,
    // pass operand b
    OP_MOVB = 3'b111
  } alu_op_e;

  // -------------------------------------------------------------------------
  // result flags
  // -------------------------------------------------------------------------

  // overflow sits in the msb, zero in the lsb
  typedef struct packed {
    // signed overflow, add/sub/inc only
    logic overflow;
    // copy of the result msb
    logic negative;
    // result is all zeros
    logic zero;
  } alu_flags_t;

  // ops that go through the adder
  function automatic logic is_arith_op(alu_op_e op);
    return (op == OP_ADD) || (op == OP_SUB) || (op == OP_INC);
  endfunction

endpackage
